// ==== common/coreIsaPkg.sv ====
// Core instruction set definitions
`default_nettype none

package coreIsaPkg;

	// One register value
	typedef logic [31:0] dataWord;

	// Register number, R0 reads as zero
	typedef logic [3:0] regIndex;

	typedef enum logic [3:0]
	{
		NOP  = 4'h0,	// All-zero word
		ADD  = 4'h1,
		SUB  = 4'h2,
		AND  = 4'h3,
		OR   = 4'h4,
		XOR  = 4'h5,
		MOVI = 4'h6,
		ADDI = 4'h7,
		MUL  = 4'h8,
		ST   = 4'h9,
		BRA  = 4'hA,
		BNZ  = 4'hB
	} opcode;

	// Three-register view, Rn = Rm op Ro
	typedef struct packed
	{
		opcode op;
		regIndex rn;
		regIndex rm;
		regIndex ro;
	} regForm;

	// Register plus immediate view
	typedef struct packed
	{
		opcode op;
		regIndex rn;
		logic signed [7:0] imm;
	} immForm;

	// Opcode and rn sit at the same bits in both views
	typedef union packed
	{
		regForm r;
		immForm i;
	} instrWord;

	localparam logic [31:0] instrStep = 32'd2;	// Bytes per instruction

endpackage

`default_nettype wire

// ==== common/corePipePkg.sv ====
// Pipeline stage packets
`default_nettype none

package corePipePkg;

	// IF/ID register
	typedef struct packed
	{
		logic valid;
		logic [31:0] pc;
		coreIsaPkg::instrWord instr;
	} fetchPacket;

	// ID/EX1 register
	typedef struct packed
	{
		logic valid;
		coreIsaPkg::opcode op;
		coreIsaPkg::regIndex rn;	// Destination, or store data source
		coreIsaPkg::dataWord a;
		coreIsaPkg::dataWord b;
		logic [31:0] imm;	// Sign-extended imm8
		logic [31:0] pc;
	} decodedOp;

	// Register file write port
	typedef struct packed
	{
		logic valid;
		coreIsaPkg::regIndex index;
		coreIsaPkg::dataWord data;
	} regWrite;

	// Taken branch from EX1
	typedef struct packed
	{
		logic taken;
		logic [31:0] target;
	} branchRedirect;

	// External store port payload
	typedef struct packed
	{
		logic [31:0] addr;
		coreIsaPkg::dataWord data;
	} storeReq;

endpackage

`default_nettype wire

// ==== hdl/fetch/fetchUnit.sv ====
// Instruction fetch stage
`default_nettype none

module fetchUnit
#(
	parameter logic [31:0] resetVector = 32'h0
)
(
	input wire logic clock,
	input wire logic reset,
	input wire coreIsaPkg::instrWord fetchData,
	input wire logic stall,
	input wire corePipePkg::branchRedirect redirect,
	output logic [31:0] fetchAddr,
	output corePipePkg::fetchPacket packet
);

	logic [31:0] pc;

	assign fetchAddr = pc;

	// PC update, redirect beats stall
	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= resetVector;
		else if (redirect.taken)
			pc <= redirect.target;
		else if (!stall)
			pc <= pc + coreIsaPkg::instrStep;
	end

	// IF/ID register
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			packet.valid <= 1'b0;
		end
		else if (redirect.taken)
		begin
			packet.valid <= 1'b0;	// Flush the younger fetch
		end
		else if (!stall)
		begin
			packet.valid <= 1'b1;
			packet.pc <= pc;
			packet.instr <= fetchData;
		end
	end

	// Steps and branch targets keep the PC halfword aligned
	pcEven: assert property (@(posedge clock) disable iff (reset) fetchAddr[0] == 1'b0);

endmodule

`default_nettype wire

// ==== hdl/decode/regFile.sv ====
// General register file
`default_nettype none

module regFile
(
	input wire logic clock,
	input wire logic reset,
	input wire coreIsaPkg::regIndex readIndexA,
	input wire coreIsaPkg::regIndex readIndexB,
	output coreIsaPkg::dataWord readA,
	output coreIsaPkg::dataWord readB,
	input wire corePipePkg::regWrite aluWrite,
	input wire corePipePkg::regWrite mulWrite
);

	coreIsaPkg::dataWord regs [16];

	// EX1 result is younger, so it is checked first
	function automatic coreIsaPkg::dataWord readPort(input coreIsaPkg::regIndex idx);
		if (idx == '0)
			return '0;
		else if (aluWrite.valid && aluWrite.index == idx)
			return aluWrite.data;
		else if (mulWrite.valid && mulWrite.index == idx)
			return mulWrite.data;
		else
			return regs[idx];
	endfunction

	assign readA = readPort(readIndexA);
	assign readB = readPort(readIndexB);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (mulWrite.valid && mulWrite.index != '0)
				regs[mulWrite.index] <= mulWrite.data;
			if (aluWrite.valid && aluWrite.index != '0)
				regs[aluWrite.index] <= aluWrite.data;	// Wins on same index
		end
	end

	noAluZero: assert property (@(posedge clock) disable iff (reset)
		!(aluWrite.valid && aluWrite.index == '0));
	noMulZero: assert property (@(posedge clock) disable iff (reset)
		!(mulWrite.valid && mulWrite.index == '0));

endmodule

`default_nettype wire

// ==== hdl/decode/decodeUnit.sv ====
// Decode stage with operand read
`default_nettype none

module decodeUnit
(
	input wire logic clock,
	input wire logic reset,
	input wire corePipePkg::fetchPacket packet,
	input wire corePipePkg::branchRedirect redirect,
	input wire corePipePkg::regWrite mulPending,
	input wire corePipePkg::regWrite aluWrite,
	input wire corePipePkg::regWrite mulWrite,
	output logic stall,
	output corePipePkg::decodedOp op
);

	coreIsaPkg::instrWord instr;
	coreIsaPkg::regIndex srcA;
	coreIsaPkg::regIndex srcB;
	coreIsaPkg::regIndex dest;
	logic [31:0] immExt;
	coreIsaPkg::dataWord valA;
	coreIsaPkg::dataWord valB;
	logic hitA;
	logic hitB;

	assign instr = packet.instr;

	// Unused sources stay on R0
	always_comb
	begin
		srcA = '0;
		srcB = '0;
		dest = instr.i.rn;
		immExt = {{24{instr.i.imm[7]}}, instr.i.imm};
		case (instr.r.op)
			coreIsaPkg::ADD, coreIsaPkg::SUB, coreIsaPkg::AND,
			coreIsaPkg::OR, coreIsaPkg::XOR, coreIsaPkg::MUL:
			begin
				srcA = instr.r.rm;
				srcB = instr.r.ro;
			end
			coreIsaPkg::ST:
			begin
				srcA = instr.r.rn;	// Data
				srcB = instr.r.rm;	// Address
			end
			coreIsaPkg::ADDI, coreIsaPkg::BNZ:
				srcA = instr.i.rn;
			default:
				srcA = '0;
		endcase
	end

	regFile regFile_i
	(
		.clock(clock),
		.reset(reset),
		.readIndexA(srcA),
		.readIndexB(srcB),
		.readA(valA),
		.readB(valB),
		.aluWrite(aluWrite),
		.mulWrite(mulWrite)
	);

	// MUL result not ready until EX2
	assign hitA = (srcA == mulPending.index);
	assign hitB = (srcB == mulPending.index);
	assign stall = packet.valid && mulPending.valid && (mulPending.index != '0) &&
		(hitA || hitB);

	always_ff @(posedge clock)
	begin
		if (reset)
			op.valid <= 1'b0;
		else
			op.valid <= packet.valid && !stall && !redirect.taken;	// Bubble on hold or flush
	end

	always_ff @(posedge clock)
	begin
		op.op <= instr.r.op;
		op.rn <= dest;
		op.a <= valA;
		op.b <= valB;
		op.imm <= immExt;
		op.pc <= packet.pc;
	end

	// Only a MUL sitting in EX1 may hold decode
	stallOnMul: assert property (@(posedge clock) disable iff (reset)
		stall |-> (op.valid && op.op == coreIsaPkg::MUL));

endmodule

`default_nettype wire

// ==== hdl/execute/execUnit.sv ====
// Execute stages EX1 and EX2
`default_nettype none

module execUnit
(
	input wire logic clock,
	input wire logic reset,
	input wire corePipePkg::decodedOp op,
	output corePipePkg::branchRedirect redirect,
	output corePipePkg::regWrite aluWrite,
	output corePipePkg::regWrite mulPending,
	output corePipePkg::regWrite mulWrite,
	output logic storeValid,
	output corePipePkg::storeReq store
);

	coreIsaPkg::dataWord aluResult;
	logic aluOp;
	logic isMul;
	logic isStore;
	logic branchTaken;
	logic [31:0] branchTarget;
	coreIsaPkg::dataWord product;
	logic mulValid;
	coreIsaPkg::regIndex mulIndex;
	coreIsaPkg::dataWord mulData;

	// EX1 ALU
	always_comb
	begin
		aluResult = '0;
		aluOp = 1'b1;
		case (op.op)
			coreIsaPkg::ADD:
				aluResult = op.a + op.b;
			coreIsaPkg::SUB:
				aluResult = op.a - op.b;
			coreIsaPkg::AND:
				aluResult = op.a & op.b;
			coreIsaPkg::OR:
				aluResult = op.a | op.b;
			coreIsaPkg::XOR:
				aluResult = op.a ^ op.b;
			coreIsaPkg::MOVI:
				aluResult = op.imm;
			coreIsaPkg::ADDI:
				aluResult = op.a + op.imm;	// a holds Rn
			default:
				aluOp = 1'b0;
		endcase
	end

	// Writes to R0 are dropped here
	assign aluWrite = '{valid: op.valid && aluOp && (op.rn != '0),
		index: op.rn, data: aluResult};

	// Branch resolve, target is pc + 2 + 2 * imm8
	assign branchTarget = op.pc + coreIsaPkg::instrStep + {op.imm[30:0], 1'b0};

	always_comb
	begin
		branchTaken = 1'b0;
		if (op.valid)
		begin
			if (op.op == coreIsaPkg::BRA)
				branchTaken = 1'b1;
			else if (op.op == coreIsaPkg::BNZ)
				branchTaken = (op.a != '0);
		end
	end

	assign redirect = '{taken: branchTaken, target: branchTarget};

	// Multiplier, low halves only
	assign isMul = (op.op == coreIsaPkg::MUL);
	assign product = op.a[15:0] * op.b[15:0];
	assign mulPending = '{valid: op.valid && isMul && (op.rn != '0),
		index: op.rn, data: '0};

	assign isStore = (op.op == coreIsaPkg::ST);

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			mulValid <= 1'b0;
			storeValid <= 1'b0;
		end
		else
		begin
			mulValid <= mulPending.valid;	// Into EX2
			storeValid <= op.valid && isStore;
		end
	end

	always_ff @(posedge clock)
	begin
		mulIndex <= op.rn;
		mulData <= product;
		store <= '{addr: op.b, data: op.a};	// Rm is address, Rn is data
	end

	// EX2 writeback
	assign mulWrite = '{valid: mulValid, index: mulIndex, data: mulData};

endmodule

`default_nettype wire

// ==== hdl/pipeCore.sv ====
// Four-stage pipeline core
`default_nettype none

module pipeCore
#(
	parameter logic [31:0] resetVector = 32'h0
)
(
	input wire logic clock,
	input wire logic reset,
	input wire coreIsaPkg::instrWord fetchData,
	output logic [31:0] fetchAddr,
	output logic storeValid,
	output corePipePkg::storeReq store
);

	corePipePkg::fetchPacket packet;
	corePipePkg::decodedOp op;
	corePipePkg::branchRedirect redirect;
	corePipePkg::regWrite mulPending;
	corePipePkg::regWrite aluWrite;
	corePipePkg::regWrite mulWrite;
	logic stall;

	fetchUnit
	#(
		.resetVector(resetVector)
	)
	fetchUnit_i
	(
		.clock(clock),
		.reset(reset),
		.fetchData(fetchData),
		.stall(stall),
		.redirect(redirect),
		.fetchAddr(fetchAddr),
		.packet(packet)
	);

	decodeUnit decodeUnit_i
	(
		.clock(clock),
		.reset(reset),
		.packet(packet),
		.redirect(redirect),
		.mulPending(mulPending),
		.aluWrite(aluWrite),
		.mulWrite(mulWrite),
		.stall(stall),
		.op(op)
	);

	execUnit execUnit_i
	(
		.clock(clock),
		.reset(reset),
		.op(op),
		.redirect(redirect),
		.aluWrite(aluWrite),
		.mulPending(mulPending),
		.mulWrite(mulWrite),
		.storeValid(storeValid),
		.store(store)
	);

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
// Testbench clock source
`default_nettype none

module clockGen
#(
	parameter int period = 8
)
(
	output logic clock
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clock = 1'b0;
		forever
			#(period / 2) clock = ~clock;
	end

endmodule

`default_nettype wire

// ==== test/coreTests.svh ====
// Directed tests and reference model
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

	task automatic regOp(coreIsaPkg::opcode op, coreIsaPkg::regIndex rn,
		coreIsaPkg::regIndex rm, coreIsaPkg::regIndex ro);
		progQueue.push_back(coreIsaPkg::instrWord'({op, rn, rm, ro}));
	endtask

	task automatic immOp(coreIsaPkg::opcode op, coreIsaPkg::regIndex rn, logic [7:0] imm);
		progQueue.push_back(coreIsaPkg::instrWord'({op, rn, imm}));
	endtask

	// Instruction-level model, one instruction per step
	task automatic computeExpected(output int steps);
		coreIsaPkg::dataWord r [16];
		coreIsaPkg::instrWord w;
		logic [31:0] pc;
		logic [31:0] next;
		logic [31:0] imm;
		int idx;
		logic halted;
		foreach (r[i])
			r[i] = '0;
		pc = resetVector;
		steps = 0;
		halted = 1'b0;
		expStores.delete();
		while (!halted)
		begin
			idx = int'((pc - resetVector) >> 1);
			w = (idx < progQueue.size()) ? progQueue[idx] : '0;
			imm = 32'(signed'(w.i.imm));
			next = pc + 32'd2;
			case (w.r.op)
				coreIsaPkg::ADD: r[w.r.rn] = r[w.r.rm] + r[w.r.ro];
				coreIsaPkg::SUB: r[w.r.rn] = r[w.r.rm] - r[w.r.ro];
				coreIsaPkg::AND: r[w.r.rn] = r[w.r.rm] & r[w.r.ro];
				coreIsaPkg::OR: r[w.r.rn] = r[w.r.rm] | r[w.r.ro];
				coreIsaPkg::XOR: r[w.r.rn] = r[w.r.rm] ^ r[w.r.ro];
				coreIsaPkg::MOVI: r[w.i.rn] = imm;
				coreIsaPkg::ADDI: r[w.i.rn] = r[w.i.rn] + imm;
				coreIsaPkg::MUL: r[w.r.rn] = {16'h0, r[w.r.rm][15:0]} * {16'h0, r[w.r.ro][15:0]};
				coreIsaPkg::ST:
					expStores.push_back(corePipePkg::storeReq'{addr: r[w.r.rm], data: r[w.r.rn]});
				coreIsaPkg::BRA: next = next + imm + imm;
				coreIsaPkg::BNZ:
					if (r[w.i.rn] != '0)
						next = next + imm + imm;
				default: ;
			endcase
			r[0] = '0;	// Zero register
			steps++;
			halted = (w.r.op == coreIsaPkg::BRA) && (next == pc);
			pc = next;
			if (steps > 4000)
			begin
				$display("Reference model never reached a halt loop");
				abortRun();
			end
		end
	endtask

	// Load, reset, run to the halt loop, then compare stores
	task automatic runProgram(string testName);
		int steps;
		logic [31:0] haltPc;
		logic [31:0] prevAddr;
		haltPc = resetVector + 32'(progQueue.size() * 2);
		immOp(coreIsaPkg::BRA, 4'd0, 8'hFF);	// Branch to self
		computeExpected(steps);
		budgetCycles += 20 * steps;
		@(posedge clock);
		reset <= 1'b1;
		@(posedge clock);
		@(negedge clock);
		checkFlag("storeValid", storeValid, 1'b0);
		for (int i = 0; i < memDepth; i++)
			progMem[i] = (i < progQueue.size()) ? progQueue[i] : '0;
		seenStores.delete();
		@(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		checkFlag("storeValid", storeValid, 1'b0);
		checkAddr("fetchAddr", fetchAddr, resetVector);
		prevAddr = fetchAddr;
		@(negedge clock);
		checkAddr("fetchAddr", fetchAddr, resetVector + 32'd2);
		// Halt seen once the final BRA redirects from two slots ahead
		while (!(prevAddr == haltPc + 32'd4 && fetchAddr == haltPc))
		begin
			prevAddr = fetchAddr;
			@(negedge clock);
		end
		if (seenStores.size() != expStores.size())
		begin
			$display("%s: %0d stores seen but %0d expected", testName,
				seenStores.size(), expStores.size());
			abortRun();
		end
		else
		begin
			foreach (expStores[i])
				checkStore($sformatf("%s store %0d", testName, i), seenStores[i], expStores[i]);
		end
		progQueue.delete();
	endtask

	task automatic resetTest();
		immOp(coreIsaPkg::MOVI, 4'd1, 8'h24);
		regOp(coreIsaPkg::ST, 4'd0, 4'd1, 4'd0);	// R0 must store zero
		regOp(coreIsaPkg::ST, 4'd1, 4'd0, 4'd0);
		runProgram("reset");
	endtask

	task automatic aluImmTest();
		coreIsaPkg::opcode ops [5];
		ops = '{coreIsaPkg::ADD, coreIsaPkg::SUB, coreIsaPkg::AND, coreIsaPkg::OR,
			coreIsaPkg::XOR};
		immOp(coreIsaPkg::MOVI, 4'd1, 8'hF9);
		immOp(coreIsaPkg::MOVI, 4'd2, 8'h35);
		immOp(coreIsaPkg::MOVI, 4'd9, 8'h40);	// Store address
		regOp(coreIsaPkg::ST, 4'd1, 4'd9, 4'd0);
		immOp(coreIsaPkg::ADDI, 4'd1, 8'h64);
		regOp(coreIsaPkg::ST, 4'd1, 4'd9, 4'd0);
		foreach (ops[k])
		begin
			regOp(ops[k], 4'(k + 3), 4'd1, 4'd2);
			regOp(coreIsaPkg::ST, 4'(k + 3), 4'd9, 4'd0);
		end
		runProgram("aluImm");
	endtask

	task automatic chainTest();
		immOp(coreIsaPkg::MOVI, 4'd1, 8'h03);
		regOp(coreIsaPkg::ADD, 4'd2, 4'd1, 4'd1);
		regOp(coreIsaPkg::SUB, 4'd3, 4'd2, 4'd1);
		regOp(coreIsaPkg::XOR, 4'd4, 4'd3, 4'd2);
		immOp(coreIsaPkg::ADDI, 4'd4, 8'hFF);
		regOp(coreIsaPkg::OR, 4'd5, 4'd4, 4'd3);
		regOp(coreIsaPkg::ST, 4'd5, 4'd2, 4'd0);
		regOp(coreIsaPkg::ST, 4'd4, 4'd5, 4'd0);
		runProgram("chain");
	endtask

	task automatic mulTest();
		immOp(coreIsaPkg::MOVI, 4'd1, 8'hFD);
		immOp(coreIsaPkg::MOVI, 4'd2, 8'h4D);
		regOp(coreIsaPkg::MUL, 4'd3, 4'd1, 4'd2);
		regOp(coreIsaPkg::ADD, 4'd4, 4'd3, 4'd1);	// Needs the interlock
		regOp(coreIsaPkg::ST, 4'd4, 4'd2, 4'd0);
		regOp(coreIsaPkg::MUL, 4'd5, 4'd2, 4'd2);
		regOp(coreIsaPkg::ADD, 4'd5, 4'd1, 4'd2);	// Same-cycle write, ALU wins
		regOp(coreIsaPkg::ST, 4'd5, 4'd1, 4'd0);
		regOp(coreIsaPkg::MUL, 4'd6, 4'd1, 4'd1);
		regOp(coreIsaPkg::ST, 4'd6, 4'd6, 4'd0);
		regOp(coreIsaPkg::ST, 4'd5, 4'd2, 4'd0);	// From the register array
		runProgram("mul");
	endtask

	task automatic branchTest();
		immOp(coreIsaPkg::MOVI, 4'd1, 8'h00);
		immOp(coreIsaPkg::MOVI, 4'd2, 8'h09);
		immOp(coreIsaPkg::BRA, 4'd0, 8'h02);	// Skips two stores
		regOp(coreIsaPkg::ST, 4'd2, 4'd2, 4'd0);
		regOp(coreIsaPkg::ST, 4'd2, 4'd2, 4'd0);
		regOp(coreIsaPkg::ST, 4'd1, 4'd2, 4'd0);
		immOp(coreIsaPkg::BNZ, 4'd1, 8'h01);	// Falls through
		regOp(coreIsaPkg::ST, 4'd2, 4'd1, 4'd0);
		immOp(coreIsaPkg::BNZ, 4'd2, 8'h01);
		regOp(coreIsaPkg::ST, 4'd1, 4'd1, 4'd0);
		immOp(coreIsaPkg::MOVI, 4'd3, 8'h03);
		regOp(coreIsaPkg::ST, 4'd3, 4'd2, 4'd0);	// Loop of three
		immOp(coreIsaPkg::ADDI, 4'd3, 8'hFF);
		immOp(coreIsaPkg::BNZ, 4'd3, 8'hFD);
		runProgram("branch");
	endtask

	task automatic randomTest();
		coreIsaPkg::regIndex rn;
		coreIsaPkg::regIndex rm;
		coreIsaPkg::regIndex ro;
		for (int k = 1; k < 16; k++)
			immOp(coreIsaPkg::MOVI, 4'(k), 8'($urandom));
		for (int k = 0; k < 48; k++)
		begin
			rn = 4'($urandom);
			rm = 4'($urandom);
			ro = 4'($urandom);
			case ($urandom % 10)
				0: regOp(coreIsaPkg::ADD, rn, rm, ro);
				1: regOp(coreIsaPkg::SUB, rn, rm, ro);
				2: regOp(coreIsaPkg::AND, rn, rm, ro);
				3: regOp(coreIsaPkg::OR, rn, rm, ro);
				4: regOp(coreIsaPkg::XOR, rn, rm, ro);
				5: regOp(coreIsaPkg::MUL, rn, rm, ro);
				6: immOp(coreIsaPkg::ADDI, rn, 8'($urandom));
				default: regOp(coreIsaPkg::ST, rn, rm, 4'd0);
			endcase
		end
		runProgram("random");
	endtask

`endif

// ==== test/pipeCoreTb.sv ====
// Pipeline core testbench
`default_nettype none

module pipeCoreTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] resetVector = 32'h0;
	localparam int memDepth = 128;	// Indexed by fetchAddr[7:1]

	logic clock;
	logic reset;
	coreIsaPkg::instrWord fetchData;
	logic [31:0] fetchAddr;
	logic storeValid;
	corePipePkg::storeReq store;

	coreIsaPkg::instrWord progMem [memDepth];
	coreIsaPkg::instrWord progQueue [$];	// Program under construction
	corePipePkg::storeReq seenStores [$];
	corePipePkg::storeReq expStores [$];
	int budgetCycles = 0;
	int elapsedCycles = 0;

	clockGen #(.period(8)) clockGen_i (.clock(clock));

	pipeCore
	#(
		.resetVector(resetVector)
	)
	dut_i
	(
		.clock(clock),
		.reset(reset),
		.fetchData(fetchData),
		.fetchAddr(fetchAddr),
		.storeValid(storeValid),
		.store(store)
	);

	assign fetchData = progMem[fetchAddr[7:1]];	// Combinational instruction read

	task automatic abortRun();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkStore(string name, corePipePkg::storeReq got,
		corePipePkg::storeReq expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %h:%h expected %h:%h", $time, name,
				got.addr, got.data, expected.addr, expected.data);
			abortRun();
		end
	endtask

	task automatic checkAddr(string name, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkFlag(string name, logic got, logic expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, expected);
			abortRun();
		end
	endtask

	// Store port sampled mid-cycle
	always @(negedge clock)
	begin
		if (storeValid)
			seenStores.push_back(store);
	end

	// Budget grows as each test is loaded
	initial
	begin
		do
		begin
			@(posedge clock);
			elapsedCycles++;
		end
		while (elapsedCycles <= budgetCycles);
		$display("Watchdog expired after %0d cycles, a program never reached its halt loop",
			elapsedCycles);
		abortRun();
	end

	`include "coreTests.svh"

	initial
	begin
		void'($urandom(32'h116b2c07));
		reset = 1'b1;
		for (int i = 0; i < memDepth; i++)
			progMem[i] = '0;
		resetTest();
		aluImmTest();
		chainTest();
		mulTest();
		branchTest();
		randomTest();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pipeCore.f ====
+incdir+test
common/coreIsaPkg.sv
common/corePipePkg.sv
hdl/fetch/fetchUnit.sv
hdl/decode/regFile.sv
hdl/decode/decodeUnit.sv
hdl/execute/execUnit.sv
hdl/pipeCore.sv
test/clockGen.sv
test/pipeCoreTb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --assert --timescale 1ns/1ps -j 0
TOP = pipeCoreTb
FILELIST = pipeCore.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf $(OBJDIR)
